//--- src/flush_pkg.sv
// shared sizes, types and constants for the branch flush unit, imported by every RTL module
package flush_pkg;

	// ============================================================
	// sizes
	// ============================================================

	// number of fetch streams, stream 0 stands for no stream at all
	localparam int XSTREAMS = 8;

	// re-order buffer depth
	localparam int ROB_ENTRIES = 16;

	// how many fork levels the dependency walk follows from the kept stream
	localparam int BRANCH_LEVELS = 3;

	// front end stages covered by the waterfall, align through rename
	localparam int FE_STAGES = 5;

	// ============================================================
	// types
	// ============================================================

	typedef logic [2:0] stream_t;
	typedef logic [XSTREAMS-1:0] stream_mask_t;
	typedef logic [31:0] pc_t;
	typedef logic [3:0] rob_ndx_t;

	// sequence numbers compare unsigned, a bigger number is a younger instruction
	typedef logic [7:0] seq_num_t;

	// instructions fetched together share one group tag
	typedef logic [5:0] group_t;

	// ============================================================
	// constants
	// ============================================================

	// the miss pc delay line starts out holding the reset vector
	localparam pc_t RSTPC = 32'hFFFC_0100;

	// with backout every branch or jump protects the rest of its group
	// without it only an untaken conditional branch does
	localparam logic SUPPORT_BACKOUT = 1'b1;

endpackage

//--- src/stream_dep_closure.sv
// combinational set of fetch streams to discard, found by walking the fork matrix from the kept stream
`timescale 1ns/1ps

module stream_dep_closure import flush_pkg::*; (
	// row i holds the streams that were forked off stream i
	input  stream_mask_t dep_stream [0:XSTREAMS-1],
	input  stream_t      kept_stream,
	output stream_mask_t stomped_streams
);

	// one-hot mask of the stream the resolving branch keeps
	stream_mask_t root;

	// reach[l] is everything found after l fork levels
	stream_mask_t reach [0:BRANCH_LEVELS];

	always_comb begin
		root = '0;
		root[kept_stream] = 1'b1;
	end

	// ============================================================
	// level by level walk
	// ============================================================

	// each level ORs in the children of every stream found so far
	// the depth is bounded so the logic stays a fixed number of gates deep
	always_comb begin
		reach[0] = root;
		for (int lvl = 0; lvl < BRANCH_LEVELS; lvl++) begin
			reach[lvl+1] = reach[lvl];
			for (int s = 0; s < XSTREAMS; s++) begin
				if (reach[lvl][s]) begin
					reach[lvl+1] = reach[lvl+1] | dep_stream[s];
				end
			end
		end
	end

	// ============================================================
	// result
	// ============================================================

	// the kept stream survives and stream 0 is never a real stream
	// so both are taken out of the discard set
	// no register here because the waterfall and the ROB logic both
	// need the set in the cycle the branch resolves
	assign stomped_streams = reach[BRANCH_LEVELS] & ~root & ~stream_mask_t'(1);

endmodule

//--- src/front_end_stomp.sv
// front end stomp waterfall that invalidates align through rename until the redirect target arrives
`timescale 1ns/1ps

module front_end_stomp import flush_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         advance,
	input  logic         advance_seg2,
	input  logic         branch_miss,
	input  logic         found_destination,
	input  pc_t          miss_pc,
	input  logic         do_bsr,
	input  stream_mask_t stomped_streams,
	input  pc_t          pc_aln,
	input  pc_t          pc_fet,
	input  pc_t          pc_mux,
	input  pc_t          pc_dec,
	input  pc_t          pc_ren,
	input  stream_t      strm_aln,
	input  stream_t      strm_fet,
	input  stream_t      strm_mux,
	input  stream_t      strm_dec,
	input  stream_t      strm_ren,
	output logic         stomp_aln,
	output logic         stomp_fet,
	output logic         stomp_mux,
	output logic         stomp_dec,
	output logic         stomp_ren
);

	logic flush_req;
	logic flush_req_q;
	logic flush_start;
	logic flush_busy;

	// entry k holds the miss pc delayed by k advances
	pc_t miss_pc_q [0:FE_STAGES-1];

	// stage views indexed from align (0) to rename (4)
	pc_t     stage_pc   [0:FE_STAGES-1];
	stream_t stage_strm [0:FE_STAGES-1];
	logic [FE_STAGES-1:0] stage_adv;
	logic [FE_STAGES-1:0] pc_match;
	logic [FE_STAGES-1:0] sticky;
	logic [FE_STAGES-1:0] stomp_vec;

	assign stage_pc[0] = pc_aln;
	assign stage_pc[1] = pc_fet;
	assign stage_pc[2] = pc_mux;
	assign stage_pc[3] = pc_dec;
	assign stage_pc[4] = pc_ren;

	assign stage_strm[0] = strm_aln;
	assign stage_strm[1] = strm_fet;
	assign stage_strm[2] = strm_mux;
	assign stage_strm[3] = strm_dec;
	assign stage_strm[4] = strm_ren;

	// decode and rename sit in the second pipeline segment
	assign stage_adv = {advance_seg2, advance_seg2, advance, advance, advance};

	// ============================================================
	// flush start detection
	// ============================================================

	// a found destination means the ROB handles the miss and the front end keeps running
	assign flush_req = branch_miss & ~found_destination;

	// the previous level is only sampled on advance so a stalled flush stays a start
	always_ff @(posedge clk) begin
		if (rst) begin
			flush_req_q <= 1'b0;
		end else if (advance) begin
			flush_req_q <= flush_req;
		end
	end

	assign flush_start = flush_req & ~flush_req_q;

	// ============================================================
	// miss pc delay line
	// ============================================================

	// the target pc walks down alongside the stage it should appear in
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < FE_STAGES; k++) begin
				miss_pc_q[k] <= RSTPC;
			end
		end else begin
			if (flush_start) begin
				miss_pc_q[0] <= miss_pc;
			end
			if (advance | flush_start) begin
				for (int k = 1; k < FE_STAGES; k++) begin
					miss_pc_q[k] <= miss_pc_q[k-1];
				end
			end
		end
	end

	// ============================================================
	// per stage stomp
	// ============================================================

	// a stage dies when its stream was discarded or when it holds
	// anything other than the redirected pc while the flush is live
	always_comb begin
		for (int k = 0; k < FE_STAGES; k++) begin
			pc_match[k] = (stage_pc[k] == miss_pc_q[k]);
			stomp_vec[k] = stomped_streams[stage_strm[k]] |
				((flush_start | sticky[k]) & ~pc_match[k]);
		end
	end

	// after reset every stage but align waits for the reset vector to arrive
	always_ff @(posedge clk) begin
		if (rst) begin
			sticky <= {{(FE_STAGES-1){1'b1}}, 1'b0};
			flush_busy <= 1'b0;
		end else if (flush_start) begin
			sticky <= '1;
			flush_busy <= 1'b1;
		end else begin
			// when idle the align flag follows do_bsr so the group after a call is dropped
			if (stage_adv[0]) begin
				if (pc_match[0])
					sticky[0] <= 1'b0;
				else if (!flush_busy)
					sticky[0] <= do_bsr;
			end
			for (int k = 1; k < FE_STAGES; k++) begin
				if (stage_adv[k] && pc_match[k])
					sticky[k] <= 1'b0;
			end
			// the flush is over once the target reaches rename
			if (stage_adv[FE_STAGES-1] && pc_match[FE_STAGES-1])
				flush_busy <= 1'b0;
		end
	end

	assign stomp_aln = stomp_vec[0];
	assign stomp_fet = stomp_vec[1];
	assign stomp_mux = stomp_vec[2];
	assign stomp_dec = stomp_vec[3];
	assign stomp_ren = stomp_vec[4];

endmodule

//--- src/rob_stomp.sv
// registered per entry stomp vector for the re-order buffer after a branch resolves
`timescale 1ns/1ps

module rob_stomp import flush_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   branch_resolved,
	input  logic                   branch_miss,
	input  logic                   found_destination,
	input  rob_ndx_t               destination_ndx,
	input  rob_ndx_t               miss_ndx,
	input  logic                   fcu_valid,
	input  rob_ndx_t               fcu_ndx,
	input  logic                   fcu_is_branch,
	input  logic                   taken,
	input  seq_num_t               rob_sn     [0:ROB_ENTRIES-1],
	input  stream_t                rob_stream [0:ROB_ENTRIES-1],
	input  group_t                 rob_grp    [0:ROB_ENTRIES-1],
	input  stream_mask_t           stomped_streams,
	input  stream_t                kept_stream,
	output logic [ROB_ENTRIES-1:0] rob_stomp
);

	logic [ROB_ENTRIES-1:0] stomp_next;
	seq_num_t miss_sn;
	seq_num_t dest_sn;
	seq_num_t fcu_sn;
	group_t   fcu_grp;
	logic     backout;

	// ages and group of the entries that anchor the decision
	assign miss_sn = rob_sn[miss_ndx];
	assign dest_sn = rob_sn[destination_ndx];
	assign fcu_sn  = rob_sn[fcu_ndx];
	assign fcu_grp = rob_grp[fcu_ndx];

	// younger group mates of the resolving branch keep their slot so their
	// register mappings can be backed out instead of thrown away
	assign backout = SUPPORT_BACKOUT ? (fcu_valid & fcu_is_branch) :
		(fcu_valid & fcu_is_branch & ~taken);

	// ============================================================
	// per entry decision
	// ============================================================

	always_comb begin
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			stomp_next[n] = 1'b0;
			if (branch_resolved) begin
				if (found_destination) begin
					// only the wrong path between the miss and its target goes
					if (rob_sn[n] > miss_sn && rob_sn[n] < dest_sn)
						stomp_next[n] = 1'b1;
				end else if (branch_miss && fcu_valid) begin
					// everything younger on a stream that is not kept
					if (rob_sn[n] > miss_sn && rob_stream[n] != kept_stream)
						stomp_next[n] = 1'b1;
				end
				if (backout && rob_grp[n] == fcu_grp && rob_sn[n] > fcu_sn)
					stomp_next[n] = 1'b0;
			end
			// dependent streams die whatever the branch did
			if (stomped_streams[rob_stream[n]])
				stomp_next[n] = 1'b1;
		end
	end

	// the vector fans out widely so it leaves through a register
	always_ff @(posedge clk) begin
		if (rst) begin
			rob_stomp <= '0;
		end else begin
			rob_stomp <= stomp_next;
		end
	end

endmodule

//--- src/branch_flush_unit.sv
// top level of the branch miss flush unit tying the stream closure to the front end and ROB stomps
`timescale 1ns/1ps

module branch_flush_unit import flush_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  stream_mask_t           dep_stream [0:XSTREAMS-1],
	input  stream_t                kept_stream,
	input  logic                   advance,
	input  logic                   advance_seg2,
	input  logic                   branch_miss,
	input  logic                   found_destination,
	input  pc_t                    miss_pc,
	input  logic                   do_bsr,
	input  pc_t                    pc_aln,
	input  pc_t                    pc_fet,
	input  pc_t                    pc_mux,
	input  pc_t                    pc_dec,
	input  pc_t                    pc_ren,
	input  stream_t                strm_aln,
	input  stream_t                strm_fet,
	input  stream_t                strm_mux,
	input  stream_t                strm_dec,
	input  stream_t                strm_ren,
	input  logic                   branch_resolved,
	input  rob_ndx_t               destination_ndx,
	input  rob_ndx_t               miss_ndx,
	input  logic                   fcu_valid,
	input  rob_ndx_t               fcu_ndx,
	input  logic                   fcu_is_branch,
	input  logic                   taken,
	input  seq_num_t               rob_sn     [0:ROB_ENTRIES-1],
	input  stream_t                rob_stream [0:ROB_ENTRIES-1],
	input  group_t                 rob_grp    [0:ROB_ENTRIES-1],
	output logic                   stomp_aln,
	output logic                   stomp_fet,
	output logic                   stomp_mux,
	output logic                   stomp_dec,
	output logic                   stomp_ren,
	output logic [ROB_ENTRIES-1:0] rob_stomp
);

	// discard set shared by both stomp paths in the same cycle
	stream_mask_t stomped_streams;

	stream_dep_closure u_closure (
		.dep_stream(dep_stream), .kept_stream(kept_stream), .stomped_streams(stomped_streams)
	);

	front_end_stomp u_front (
		.clk(clk), .rst(rst), .advance(advance), .advance_seg2(advance_seg2),
		.branch_miss(branch_miss), .found_destination(found_destination),
		.miss_pc(miss_pc), .do_bsr(do_bsr), .stomped_streams(stomped_streams),
		.pc_aln(pc_aln), .pc_fet(pc_fet), .pc_mux(pc_mux), .pc_dec(pc_dec), .pc_ren(pc_ren),
		.strm_aln(strm_aln), .strm_fet(strm_fet), .strm_mux(strm_mux),
		.strm_dec(strm_dec), .strm_ren(strm_ren),
		.stomp_aln(stomp_aln), .stomp_fet(stomp_fet), .stomp_mux(stomp_mux),
		.stomp_dec(stomp_dec), .stomp_ren(stomp_ren)
	);

	// rob_stomp lands one cycle after the resolve inputs
	rob_stomp u_rob (
		.clk(clk), .rst(rst), .branch_resolved(branch_resolved), .branch_miss(branch_miss),
		.found_destination(found_destination), .destination_ndx(destination_ndx),
		.miss_ndx(miss_ndx), .fcu_valid(fcu_valid), .fcu_ndx(fcu_ndx),
		.fcu_is_branch(fcu_is_branch), .taken(taken), .rob_sn(rob_sn),
		.rob_stream(rob_stream), .rob_grp(rob_grp), .stomped_streams(stomped_streams),
		.kept_stream(kept_stream), .rob_stomp(rob_stomp)
	);

endmodule

//--- test/flush_checker.sv
// monitor that compares the flush unit outputs with the testbench model and counts mismatches
`timescale 1ns/1ps

module flush_checker import flush_pkg::*; (
	input  logic                   clk,
	input  logic                   enable,
	input  logic [FE_STAGES-1:0]   stomp_dut,
	input  logic [FE_STAGES-1:0]   stomp_exp,
	input  logic [ROB_ENTRIES-1:0] rob_dut,
	input  logic [ROB_ENTRIES-1:0] rob_exp,
	output int                     checks,
	output int                     errors
);

	initial begin
		checks = 0;
		errors = 0;
	end

	// stage stomps are combinational and rob_stomp is registered
	// so both have settled long before the falling edge
	always @(negedge clk) begin
		if (enable) begin
			checks = checks + 2;
			// bit 0 is align and bit 4 is rename
			if (stomp_dut !== stomp_exp) begin
				errors++;
				$display("mismatch at %0d ns: stage stomps %b, model %b", $time, stomp_dut,
					stomp_exp);
			end
			if (rob_dut !== rob_exp) begin
				errors++;
				$display("mismatch at %0d ns: rob_stomp %h, model %h", $time, rob_dut, rob_exp);
			end
		end
	end

endmodule

//--- test/flush_sva.sv
// concurrent assertions bound into rob_stomp, covering its reset state and entries of the kept stream
`timescale 1ns/1ps

module flush_sva import flush_pkg::*; (
	input logic                   clk,
	input logic                   rst,
	input logic                   found_destination,
	input stream_t                kept_stream,
	input stream_t                rob_stream [0:ROB_ENTRIES-1],
	input stream_mask_t           stomped_streams,
	input logic [ROB_ENTRIES-1:0] rob_stomp
);

	// read by the testbench at the end of the run
	int fail_count = 0;

	// the first edge with reset high clears the whole vector
	reset_clear: assert property (@(posedge clk) rst |=> rob_stomp == '0)
		else begin
			$error("rob_stomp not cleared in the cycle after reset");
			fail_count++;
		end

	// without a found destination the kept stream only dies through the closure
	for (genvar n = 0; n < ROB_ENTRIES; n++) begin : g_entry
		kept_safe: assert property (@(posedge clk) disable iff (rst)
			(!found_destination && rob_stream[n] == kept_stream &&
			!stomped_streams[rob_stream[n]]) |=> !rob_stomp[n])
			else begin
				$error("entry %0d on the kept stream was stomped", n);
				fail_count++;
			end
	end

endmodule

bind rob_stomp flush_sva u_sva (
	.clk(clk), .rst(rst), .found_destination(found_destination), .kept_stream(kept_stream),
	.rob_stream(rob_stream), .stomped_streams(stomped_streams), .rob_stomp(rob_stomp)
);

//--- test/tb_branch_flush.sv
// testbench for the branch flush unit, drives seeded random traffic and checks it against a model
`timescale 1ns/1ps

module tb_branch_flush import flush_pkg::*; ();

	localparam int NUM_CYCLES = 3000;

	logic clk;
	logic rst;
	stream_mask_t dep_stream [0:XSTREAMS-1];
	stream_t kept_stream;
	logic advance, advance_seg2, branch_miss, found_destination, do_bsr;
	pc_t miss_pc;
	// stage pcs and streams, index 0 is align and 4 is rename
	pc_t pc_st [0:FE_STAGES-1];
	stream_t strm_st [0:FE_STAGES-1];
	logic branch_resolved, fcu_valid, fcu_is_branch, taken;
	rob_ndx_t destination_ndx, miss_ndx, fcu_ndx;
	seq_num_t rob_sn [0:ROB_ENTRIES-1];
	stream_t rob_stream [0:ROB_ENTRIES-1];
	group_t rob_grp [0:ROB_ENTRIES-1];
	logic stomp_aln, stomp_fet, stomp_mux, stomp_dec, stomp_ren;
	logic [ROB_ENTRIES-1:0] rob_stomp;

	// model state
	logic m_req_q, m_busy, flush_start;
	logic [FE_STAGES-1:0] m_sticky, exp_stomp;
	pc_t m_line [0:FE_STAGES-1];
	logic [ROB_ENTRIES-1:0] m_rob;
	stream_mask_t exp_closure;
	int checks, errors;

	branch_flush_unit UUT (
		.clk(clk), .rst(rst), .dep_stream(dep_stream), .kept_stream(kept_stream),
		.advance(advance), .advance_seg2(advance_seg2), .branch_miss(branch_miss),
		.found_destination(found_destination), .miss_pc(miss_pc), .do_bsr(do_bsr),
		.pc_aln(pc_st[0]), .pc_fet(pc_st[1]), .pc_mux(pc_st[2]), .pc_dec(pc_st[3]),
		.pc_ren(pc_st[4]), .strm_aln(strm_st[0]), .strm_fet(strm_st[1]),
		.strm_mux(strm_st[2]), .strm_dec(strm_st[3]), .strm_ren(strm_st[4]),
		.branch_resolved(branch_resolved), .destination_ndx(destination_ndx),
		.miss_ndx(miss_ndx), .fcu_valid(fcu_valid), .fcu_ndx(fcu_ndx),
		.fcu_is_branch(fcu_is_branch), .taken(taken), .rob_sn(rob_sn),
		.rob_stream(rob_stream), .rob_grp(rob_grp), .stomp_aln(stomp_aln),
		.stomp_fet(stomp_fet), .stomp_mux(stomp_mux), .stomp_dec(stomp_dec),
		.stomp_ren(stomp_ren), .rob_stomp(rob_stomp)
	);

	flush_checker u_check (
		.clk(clk), .enable(!rst), .stomp_exp(exp_stomp), .rob_dut(rob_stomp), .rob_exp(m_rob),
		.stomp_dut({stomp_ren, stomp_dec, stomp_mux, stomp_fet, stomp_aln}),
		.checks(checks), .errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ============================================================
	// reference model
	// ============================================================

	// discard set, then the same cycle stage stomps from model state
	always_comb begin
		stream_mask_t seen;
		stream_mask_t grown;
		seen = stream_mask_t'(1) << kept_stream;
		for (int lvl = 0; lvl < BRANCH_LEVELS; lvl++) begin
			grown = seen;
			for (int i = 0; i < XSTREAMS; i++)
				if (seen[i])
					grown = grown | dep_stream[i];
			seen = grown;
		end
		exp_closure = seen & ~(stream_mask_t'(1) << kept_stream) & ~stream_mask_t'(1);
		flush_start = branch_miss && !found_destination && !m_req_q;
		for (int k = 0; k < FE_STAGES; k++)
			exp_stomp[k] = exp_closure[strm_st[k]] ||
				((flush_start || m_sticky[k]) && pc_st[k] != m_line[k]);
	end

	always @(posedge clk) begin
		logic [FE_STAGES-1:0] adv;
		logic start;
		logic exempt;
		adv = {advance_seg2, advance_seg2, advance, advance, advance};
		start = flush_start;
		exempt = fcu_valid && fcu_is_branch && (SUPPORT_BACKOUT || !taken);
		if (rst) begin
			m_req_q = 1'b0;
			m_busy = 1'b0;
			m_sticky = 5'b11110;
			m_rob = '0;
			for (int k = 0; k < FE_STAGES; k++)
				m_line[k] = RSTPC;
		end else begin
			for (int n = 0; n < ROB_ENTRIES; n++) begin
				m_rob[n] = 1'b0;
				if (branch_resolved && found_destination)
					m_rob[n] = rob_sn[n] > rob_sn[miss_ndx] && rob_sn[n] < rob_sn[destination_ndx];
				else if (branch_resolved && branch_miss && fcu_valid)
					m_rob[n] = rob_sn[n] > rob_sn[miss_ndx] && rob_stream[n] != kept_stream;
				// group mates younger than the resolving branch are backed out instead
				if (branch_resolved && exempt && rob_grp[n] == rob_grp[fcu_ndx] &&
					rob_sn[n] > rob_sn[fcu_ndx])
					m_rob[n] = 1'b0;
				m_rob[n] = m_rob[n] || exp_closure[rob_stream[n]];
			end
			if (start) begin
				m_sticky = '1;
				m_busy = 1'b1;
			end else begin
				// the align flag sees the flush state from before this edge
				for (int k = 0; k < FE_STAGES; k++)
					if (adv[k] && pc_st[k] == m_line[k])
						m_sticky[k] = 1'b0;
					else if (k == 0 && advance && !m_busy)
						m_sticky[0] = do_bsr;
				if (advance_seg2 && pc_st[4] == m_line[4])
					m_busy = 1'b0;
			end
			// the line shifts with the old entries, then takes the new target
			if (advance || start)
				for (int k = FE_STAGES - 1; k > 0; k--)
					m_line[k] = m_line[k-1];
			if (start)
				m_line[0] = miss_pc;
			if (advance)
				m_req_q = branch_miss && !found_destination;
		end
	end

	// ============================================================
	// stimulus
	// ============================================================

	task automatic idle_inputs();
		for (int s = 0; s < XSTREAMS; s++)
			dep_stream[s] = '0;
		{kept_stream, advance, advance_seg2, branch_miss, found_destination, do_bsr} = '0;
		{branch_resolved, fcu_valid, fcu_is_branch, taken} = '0;
		{destination_ndx, miss_ndx, fcu_ndx} = '0;
		miss_pc = '0;
		for (int k = 0; k < FE_STAGES; k++) begin
			pc_st[k] = '0;
			strm_st[k] = '0;
		end
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			rob_sn[n] = seq_num_t'(n);
			rob_stream[n] = '0;
			rob_grp[n] = '0;
		end
	endtask

	// a small pc pool so stage pcs often hit the delayed target
	task automatic drive_cycle();
		logic [255:0] used;
		seq_num_t sn;
		used = '0;
		for (int s = 0; s < XSTREAMS; s++)
			dep_stream[s] = stream_mask_t'($urandom & $urandom & $urandom & $urandom);
		kept_stream = stream_t'($urandom);
		advance = ($urandom % 4) != 0;
		advance_seg2 = ($urandom % 4) != 0;
		branch_miss = ($urandom % 4) == 0;
		found_destination = ($urandom % 3) == 0;
		do_bsr = ($urandom % 8) == 0;
		miss_pc = 32'h1000 + (($urandom % 4) << 2);
		for (int k = 0; k < FE_STAGES; k++) begin
			pc_st[k] = ($urandom % 2) ? m_line[k] : 32'h1000 + (($urandom % 4) << 2);
			strm_st[k] = stream_t'($urandom);
		end
		branch_resolved = $urandom % 2;
		{fcu_valid, fcu_is_branch, taken} = 3'($urandom);
		miss_ndx = rob_ndx_t'($urandom);
		destination_ndx = rob_ndx_t'($urandom);
		fcu_ndx = ($urandom % 2) ? miss_ndx : rob_ndx_t'($urandom);
		// distinct ages across the whole buffer
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			do
				sn = seq_num_t'($urandom);
			while (used[sn]);
			used[sn] = 1'b1;
			rob_sn[n] = sn;
			rob_stream[n] = stream_t'($urandom);
			rob_grp[n] = group_t'($urandom % 4);
		end
	endtask

	initial begin
		void'($urandom(82));
		idle_inputs();
		rst = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (NUM_CYCLES) begin
			@(posedge clk);
			#1;
			drive_cycle();
		end
		repeat (2) @(negedge clk);
		$display("checks %0d, mismatches %0d, assertion failures %0d", checks, errors,
			UUT.u_rob.u_sva.fail_count);
		if (errors == 0 && UUT.u_rob.u_sva.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// watchdog sized from reset, the random cycles and a margin
	initial begin
		#((16 + NUM_CYCLES + 50) * 4);
		$display("timeout: the run did not finish within %0d cycles", 16 + NUM_CYCLES + 50);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- branch_flush.f
src/flush_pkg.sv
src/stream_dep_closure.sv
src/front_end_stomp.sv
src/rob_stomp.sv
src/branch_flush_unit.sv
test/flush_checker.sv
test/flush_sva.sv
test/tb_branch_flush.sv
